// ==== verilog/attn_pkg.sv ====
package attn_pkg;

    localparam int MAT_N     = 4;             // matrix edge, also array size
    localparam int ELEM_W    = 8;
    localparam int ACC_W     = 32;
    localparam int REQ_SHIFT = 5;             // requantization right shift
    localparam int ELEM_MAX  = 127;
    localparam int ELEM_MIN  = -128;
    localparam int SA_LAT    = 3 * MAT_N;     // start to done, in cycles

    // one matrix element and one accumulator
    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // row / column index inside a tile
    typedef logic [$clog2(MAT_N)-1:0] idx_t;

    // systolic step counter, must reach SA_LAT
    typedef logic [$clog2(SA_LAT+1)-1:0] sa_cnt_t;

    // whole tiles, indexed [row][col]
    typedef elem_t [MAT_N-1:0][MAT_N-1:0] mat_t;
    typedef acc_t  [MAT_N-1:0][MAT_N-1:0] acc_mat_t;

endpackage

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    import attn_pkg::*;

    localparam int NUM_SLOTS = 4;

    // buffer slot code
    typedef enum logic [1:0] {
        SLOT_Q,
        SLOT_K,
        SLOT_V,
        SLOT_O
    } slot_e;

    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        slot_e slot;
        mat_t  wdata;
    } buf_req_t;

    typedef struct packed {
        logic  rd_vld;
        mat_t  rdata;
        logic  wr_done;
    } buf_rsp_t;

endpackage

// ==== verilog/attn_ctrl.sv ====
`timescale 1ns/1ps
module attn_ctrl
    import attn_pkg::*;
    import mem_pkg::*;
(
    input  logic     clk       ,
    input  logic     arst_n    ,
    input  logic     attn_start,
    output buf_req_t buf_req   ,
    input  buf_rsp_t buf_rsp   ,
    output logic     sa_start  ,
    output mat_t     sa_x      ,
    output mat_t     sa_w      ,
    input  logic     sa_done   ,
    input  acc_mat_t sa_result ,
    output logic     busy      ,
    output logic     attn_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_Q,
        ST_RD_K,
        ST_JOB1,
        ST_RD_V,
        ST_JOB2,
        ST_WRITE,
        ST_DONE
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   issued;       // request of this state already sent
    logic   rd_ack;
    logic   wr_ack;
    logic   job_ack;
    logic   step_done;
    mat_t   op_x;         // left operand, Q then requantized S
    mat_t   op_w;         // top operand, K^T then V
    mat_t   res_mat;      // requantized O, goes to the buffer

    function automatic elem_t requant(acc_t a);
        acc_t sh;
        sh = a >>> REQ_SHIFT;   // arithmetic, keeps the sign
        if (sh > acc_t'(ELEM_MAX)) begin
            return elem_t'(ELEM_MAX);
        end
        if (sh < acc_t'(ELEM_MIN)) begin
            return elem_t'(ELEM_MIN);
        end
        return elem_t'(sh);
    endfunction

    function automatic mat_t requant_mat(acc_mat_t m);
        mat_t r;
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                r[i][j] = requant(m[i][j]);
            end
        end
        return r;
    endfunction

    function automatic mat_t transpose(mat_t m);
        mat_t t;
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                t[i][j] = m[j][i];
            end
        end
        return t;
    endfunction

    // a response only counts once our own request went out
    assign rd_ack  = issued && buf_rsp.rd_vld;
    assign wr_ack  = issued && buf_rsp.wr_done;
    assign job_ack = issued && sa_done;

    always_comb begin
        step_done = 1'b0;
        state_nxt = state;
        case (state)
            ST_RD_Q: begin
                step_done = rd_ack;
                state_nxt = ST_RD_K;
            end
            ST_RD_K: begin
                step_done = rd_ack;
                state_nxt = ST_JOB1;
            end
            ST_JOB1: begin
                step_done = job_ack;
                state_nxt = ST_RD_V;
            end
            ST_RD_V: begin
                step_done = rd_ack;
                state_nxt = ST_JOB2;
            end
            ST_JOB2: begin
                step_done = job_ack;
                state_nxt = ST_WRITE;
            end
            ST_WRITE: begin
                step_done = wr_ack;
                state_nxt = ST_DONE;
            end
            default: begin
                step_done = 1'b0;
                state_nxt = state;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_IDLE;
            issued <= 1'b0;
        end else if (state == ST_IDLE || state == ST_DONE) begin
            issued <= 1'b0;
            if (attn_start) begin
                state <= ST_RD_Q;
            end
        end else if (!issued) begin
            issued <= 1'b1;
        end else if (step_done) begin
            issued <= 1'b0;
            state  <= state_nxt;
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        if (step_done) begin
            case (state)
                ST_RD_Q: op_x    <= buf_rsp.rdata;
                ST_RD_K: op_w    <= transpose(buf_rsp.rdata);
                ST_JOB1: op_x    <= requant_mat(sa_result);   // S feeds job 2
                ST_RD_V: op_w    <= buf_rsp.rdata;
                ST_JOB2: res_mat <= requant_mat(sa_result);
                default: ;
            endcase
        end
    end

    always_comb begin
        buf_req       = '0;
        buf_req.wdata = res_mat;
        case (state)
            ST_RD_Q: begin
                buf_req.rd_en = !issued;
                buf_req.slot  = SLOT_Q;
            end
            ST_RD_K: begin
                buf_req.rd_en = !issued;
                buf_req.slot  = SLOT_K;
            end
            ST_RD_V: begin
                buf_req.rd_en = !issued;
                buf_req.slot  = SLOT_V;
            end
            ST_WRITE: begin
                buf_req.wr_en = !issued;
                buf_req.slot  = SLOT_O;
            end
            default: ;
        endcase
    end

    assign sa_start  = !issued && (state == ST_JOB1 || state == ST_JOB2);
    assign sa_x      = op_x;
    assign sa_w      = op_w;
    assign busy      = (state != ST_IDLE) && (state != ST_DONE);
    assign attn_done = (state == ST_DONE);   // held until the next start

endmodule

// ==== verilog/mat_buffer.sv ====
`timescale 1ns/1ps
module mat_buffer
    import attn_pkg::*;
    import mem_pkg::*;
(
    input  logic     clk   ,
    input  logic     arst_n,
    input  buf_req_t req   ,
    output buf_rsp_t rsp
);

    mat_t slots [NUM_SLOTS];
    logic rd_vld_q;
    logic wr_done_q;
    mat_t rdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                slots[s] <= '0;
            end
            rd_vld_q  <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            rd_vld_q  <= req.rd_en;
            wr_done_q <= req.wr_en;   // slot is updated on this same edge
            if (req.wr_en) begin
                slots[req.slot] <= req.wdata;
            end
        end
    end

    // read sees the contents before a same-cycle write
    always_ff @(posedge clk) begin
        if (req.rd_en) begin
            rdata_q <= slots[req.slot];
        end
    end

    assign rsp.rd_vld  = rd_vld_q;
    assign rsp.rdata   = rdata_q;
    assign rsp.wr_done = wr_done_q;

endmodule

// ==== verilog/systolic_array.sv ====
`timescale 1ns/1ps
module systolic_array
    import attn_pkg::*;
(
    input  logic     clk      ,
    input  logic     arst_n   ,
    input  logic     sa_start ,
    input  mat_t     sa_x     ,
    input  mat_t     sa_w     ,
    output logic     sa_done  ,
    output acc_mat_t sa_result
);

    logic     run;
    sa_cnt_t  cnt;                          // 1 in the cycle after start
    idx_t     k_idx;                        // operand index fed this step
    elem_t    x_raw  [MAT_N];               // column k of X, unskewed
    elem_t    w_raw  [MAT_N];               // row k of W, unskewed
    elem_t    x_dly  [MAT_N][MAT_N-1];      // row skew chains
    elem_t    w_dly  [MAT_N][MAT_N-1];      // column skew chains
    elem_t    x_feed [MAT_N];
    elem_t    w_feed [MAT_N];
    elem_t    x_in   [MAT_N][MAT_N];
    elem_t    w_in   [MAT_N][MAT_N];
    elem_t    x_pass [MAT_N][MAT_N];        // operand moving right
    elem_t    w_pass [MAT_N][MAT_N];        // operand moving down
    acc_mat_t acc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
            cnt <= '0;
        end else if (sa_start) begin
            run <= 1'b1;
            cnt <= sa_cnt_t'(1);
        end else if (sa_done) begin
            run <= 1'b0;
        end else if (run) begin
            cnt <= cnt + 1'b1;
        end
    end

    // last MAC lands at cnt 10, result is stable from there
    assign sa_done = run && (cnt == sa_cnt_t'(SA_LAT));
    assign k_idx   = idx_t'(cnt - 1'b1);

    always_comb begin
        for (int i = 0; i < MAT_N; i++) begin
            x_raw[i] = '0;
            w_raw[i] = '0;
            if (run && cnt <= sa_cnt_t'(MAT_N)) begin
                x_raw[i] = sa_x[i][k_idx];
                w_raw[i] = sa_w[k_idx][i];
            end
        end
    end

    // row i and column j enter i resp. j cycles late
    always_comb begin
        x_feed[0] = x_raw[0];
        w_feed[0] = w_raw[0];
        for (int i = 1; i < MAT_N; i++) begin
            x_feed[i] = x_dly[i][i-1];
            w_feed[i] = w_dly[i][i-1];
        end
    end

    always_comb begin
        for (int i = 0; i < MAT_N; i++) begin
            x_in[i][0] = x_feed[i];
            w_in[0][i] = w_feed[i];
            for (int j = 1; j < MAT_N; j++) begin
                x_in[i][j] = x_pass[i][j-1];
                w_in[j][i] = w_pass[j-1][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sa_start) begin
            for (int i = 0; i < MAT_N; i++) begin
                for (int d = 0; d < MAT_N - 1; d++) begin
                    x_dly[i][d] <= '0;
                    w_dly[i][d] <= '0;
                end
                for (int j = 0; j < MAT_N; j++) begin
                    x_pass[i][j] <= '0;
                    w_pass[i][j] <= '0;
                    acc[i][j]    <= '0;
                end
            end
        end else if (run) begin
            for (int i = 0; i < MAT_N; i++) begin
                x_dly[i][0] <= x_raw[i];
                w_dly[i][0] <= w_raw[i];
                for (int d = 1; d < MAT_N - 1; d++) begin
                    x_dly[i][d] <= x_dly[i][d-1];
                    w_dly[i][d] <= w_dly[i][d-1];
                end
                for (int j = 0; j < MAT_N; j++) begin
                    acc[i][j]    <= acc[i][j] + x_in[i][j] * w_in[i][j];   // MAC cell
                    x_pass[i][j] <= x_in[i][j];
                    w_pass[i][j] <= w_in[i][j];
                end
            end
        end
    end

    assign sa_result = acc;   // frozen once run drops

endmodule

// ==== verilog/attn_top.sv ====
`timescale 1ns/1ps
module attn_top
    import attn_pkg::*;
    import mem_pkg::*;
(
    input  logic  clk       ,
    input  logic  arst_n    ,
    input  logic  attn_start,
    input  logic  load_en   ,
    input  slot_e load_slot ,
    input  mat_t  load_mat  ,
    input  logic  rd_en     ,
    input  slot_e rd_slot   ,
    output logic  rd_vld    ,
    output mat_t  rd_mat    ,
    output logic  busy      ,
    output logic  attn_done
);

    buf_req_t host_req;
    buf_req_t eng_req;
    buf_req_t buf_req;     // what the buffer actually sees
    buf_rsp_t buf_rsp;
    logic     host_rd_q;   // last read came from the host
    logic     sa_start;
    logic     sa_done;
    mat_t     sa_x;
    mat_t     sa_w;
    acc_mat_t sa_result;

    always_comb begin
        host_req.rd_en = rd_en && !load_en;   // a load wins the port
        host_req.wr_en = load_en;
        host_req.slot  = load_en ? load_slot : rd_slot;
        host_req.wdata = load_mat;
    end

    // engine owns the port while busy, host strobes are dropped
    assign buf_req = busy ? eng_req : host_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            host_rd_q <= 1'b0;
        end else begin
            host_rd_q <= !busy && host_req.rd_en;
        end
    end

    assign rd_vld = buf_rsp.rd_vld && host_rd_q;
    assign rd_mat = buf_rsp.rdata;

    attn_ctrl i_attn_ctrl (
        .clk        (clk       ),
        .arst_n     (arst_n    ),
        .attn_start (attn_start),
        .buf_req    (eng_req   ),
        .buf_rsp    (buf_rsp   ),
        .sa_start   (sa_start  ),
        .sa_x       (sa_x      ),
        .sa_w       (sa_w      ),
        .sa_done    (sa_done   ),
        .sa_result  (sa_result ),
        .busy       (busy      ),
        .attn_done  (attn_done )
    );

    mat_buffer i_mat_buffer (
        .clk    (clk    ),
        .arst_n (arst_n ),
        .req    (buf_req),
        .rsp    (buf_rsp)
    );

    systolic_array i_systolic_array (
        .clk       (clk      ),
        .arst_n    (arst_n   ),
        .sa_start  (sa_start ),
        .sa_x      (sa_x     ),
        .sa_w      (sa_w     ),
        .sa_done   (sa_done  ),
        .sa_result (sa_result)
    );

endmodule

// ==== tests/attn_checker.sv ====
`timescale 1ns/1ps
module attn_checker
    import attn_pkg::*;
    import mem_pkg::*;
(
    input logic     clk      ,
    input logic     arst_n   ,
    input logic     busy     ,
    input logic     attn_done,
    input logic     sa_done  ,
    input buf_req_t buf_req  ,
    input buf_rsp_t buf_rsp
);

    sa_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        sa_done |=> !sa_done)
        else $error("sa_done stayed high for two cycles");

    wr_done_follows: assert property (@(posedge clk) disable iff (!arst_n)
        buf_req.wr_en |=> buf_rsp.wr_done)
        else $error("wr_done missing one cycle after a buffer write");

    busy_done_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(busy && attn_done))
        else $error("busy and attn_done high together");

    // while busy the only buffer write is the engine's write-back of O
    no_host_write: assert property (@(posedge clk) disable iff (!arst_n)
        busy && buf_req.wr_en |-> buf_req.slot == SLOT_O)
        else $error("host write reached the buffer while busy");

endmodule

bind attn_top attn_checker i_attn_checker (
    .clk       (clk      ),
    .arst_n    (arst_n   ),
    .busy      (busy     ),
    .attn_done (attn_done),
    .sa_done   (sa_done  ),
    .buf_req   (buf_req  ),
    .buf_rsp   (buf_rsp  )
);

// ==== tests/attn_tb.sv ====
`timescale 1ns/1ps
module attn_tb
    import attn_pkg::*;
    import mem_pkg::*;
;

    localparam int TAB_LEN      = 6;
    localparam int RD_TIMEOUT   = 8;
    localparam int DONE_TIMEOUT = 200;
    localparam int SEED         = 14;

    typedef enum logic [2:0] {PAT_IDENT, PAT_MAX, PAT_MIN, PAT_SMALL, PAT_FULL} pat_e;
    typedef enum logic [1:0] {EXP_MODEL, EXP_SAT_HI, EXP_SAT_LO} exp_e;

    typedef struct packed {
        pat_e q_kind;
        pat_e k_kind;
        pat_e v_kind;
        exp_e exp_kind;   // extra clamp check on top of the model
        logic intrude;    // poke start and loads while busy
    } stim_t;

    logic  clk;
    logic  arst_n;
    logic  attn_start;
    logic  load_en;
    slot_e load_slot;
    mat_t  load_mat;
    logic  rd_en;
    slot_e rd_slot;
    logic  rd_vld;
    mat_t  rd_mat;
    logic  busy;
    logic  attn_done;
    stim_t stim_tab [TAB_LEN];
    int    errors;
    int    timeouts;
    int    first_rnd;
    logic  ended;

    attn_top i_attn_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int to_int(elem_t e);
        return int'(e);
    endfunction

    // floor division by 2**REQ_SHIFT, then clamp to the 8-bit range
    function automatic elem_t shift_clamp(int sum);
        int div;
        int q;
        div = 1 << REQ_SHIFT;
        q   = sum / div;
        if (sum < 0 && q * div != sum) begin
            q = q - 1;   // division truncates toward zero
        end
        if (q > 127) begin
            q = 127;
        end else if (q < -128) begin
            q = -128;
        end
        return elem_t'(q);
    endfunction

    // O = rq(rq(Q * K^T) * V)
    function automatic mat_t expected_out(mat_t q, mat_t k, mat_t v);
        mat_t s;
        mat_t o;
        int   sum;
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                sum = 0;
                for (int n = 0; n < MAT_N; n++) begin
                    sum += to_int(q[i][n]) * to_int(k[j][n]);
                end
                s[i][j] = shift_clamp(sum);
            end
        end
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                sum = 0;
                for (int n = 0; n < MAT_N; n++) begin
                    sum += to_int(s[i][n]) * to_int(v[n][j]);
                end
                o[i][j] = shift_clamp(sum);
            end
        end
        return o;
    endfunction

    function automatic mat_t make_matrix(pat_e kind);
        mat_t m;
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                case (kind)
                    PAT_IDENT: m[i][j] = (i == j) ? elem_t'(1) : elem_t'(0);
                    PAT_MAX:   m[i][j] = elem_t'(127);
                    PAT_MIN:   m[i][j] = elem_t'(-128);
                    PAT_SMALL: m[i][j] = elem_t'(int'($urandom_range(15)) - 8);   // -8..7
                    default:   m[i][j] = elem_t'($urandom);
                endcase
            end
        end
        return m;
    endfunction

    task automatic compare_matrix(string what, mat_t got, mat_t exp);
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(string what, mat_t got, elem_t level);
        int bad;
        bad = 0;
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                if (got[i][j] != level) bad++;
            end
        end
        assert (bad == 0) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s has %0d elements not at %0d",
                     $time, what, bad, to_int(level));
        end
    endtask

    task automatic write_matrix(slot_e slot, mat_t m);
        @(posedge clk);
        #1;
        load_en   = 1'b1;
        load_slot = slot;
        load_mat  = m;
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic read_matrix(input slot_e slot, output mat_t m);
        int cyc;
        @(posedge clk);
        #1;
        rd_en   = 1'b1;
        rd_slot = slot;
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        cyc   = 1;
        while (!rd_vld && cyc < RD_TIMEOUT) begin   // count cycles up to rd_vld
            @(posedge clk);
            #1;
            cyc++;
        end
        m = rd_mat;
        if (!rd_vld) begin
            timeouts++;
            $display("read of slot %s got no rd_vld within %0d cycles", slot.name(), cyc);
        end else begin
            assert (cyc == 1) else begin
                errors++;
                $display("CHECK FAILED at %0t: rd_vld came %0d cycles after rd_en", $time, cyc);
            end
        end
    endtask

    task automatic start_run();
        @(posedge clk);
        #1;
        attn_start = 1'b1;
        @(posedge clk);
        #1;
        attn_start = 1'b0;
        assert (busy && !attn_done) else begin
            errors++;
            $display("CHECK FAILED at %0t: start not accepted, busy %b attn_done %b",
                     $time, busy, attn_done);
        end
    endtask

    // second start plus loads of Q and V, all while busy
    task automatic disturb_run(mat_t q, mat_t v);
        @(posedge clk);
        #1;
        attn_start = 1'b1;
        load_en    = 1'b1;
        load_slot  = SLOT_Q;
        load_mat   = ~q;
        @(posedge clk);
        #1;
        attn_start = 1'b0;
        load_slot  = SLOT_V;
        load_mat   = ~v;
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic wait_done();
        int cyc;
        cyc = 0;
        while (!attn_done && cyc < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!attn_done) begin
            timeouts++;
            $display("attn_done did not rise within %0d cycles of the start", cyc);
        end
    endtask

    task automatic check_reset_state();
        mat_t got;
        assert (!busy && !attn_done && !rd_vld) else begin
            errors++;
            $display("CHECK FAILED at %0t: after reset busy %b attn_done %b rd_vld %b",
                     $time, busy, attn_done, rd_vld);
        end
        for (int s = 0; s < 4; s++) begin
            read_matrix(slot_e'(s), got);
            compare_matrix($sformatf("slot %0d after reset", s), got, '0);
        end
    endtask

    task automatic run_row(int r);
        stim_t row;
        mat_t  q;
        mat_t  k;
        mat_t  v;
        mat_t  o_exp;
        mat_t  got;
        row   = stim_tab[r];
        q     = make_matrix(row.q_kind);
        k     = make_matrix(row.k_kind);
        v     = make_matrix(row.v_kind);
        o_exp = expected_out(q, k, v);
        write_matrix(SLOT_Q, q);
        write_matrix(SLOT_K, k);
        write_matrix(SLOT_V, v);
        start_run();
        if (row.intrude) begin
            disturb_run(q, v);
        end
        wait_done();
        read_matrix(SLOT_O, got);
        compare_matrix($sformatf("row %0d O", r), got, o_exp);
        if (row.exp_kind == EXP_SAT_HI) begin
            check_level($sformatf("row %0d O", r), got, elem_t'(127));
        end else if (row.exp_kind == EXP_SAT_LO) begin
            check_level($sformatf("row %0d O", r), got, elem_t'(-128));
        end
        read_matrix(SLOT_Q, got);
        compare_matrix($sformatf("row %0d Q readback", r), got, q);
        read_matrix(SLOT_K, got);
        compare_matrix($sformatf("row %0d K readback", r), got, k);
        read_matrix(SLOT_V, got);
        compare_matrix($sformatf("row %0d V readback", r), got, v);
    endtask

    task automatic fill_table();
        stim_tab[0] = '{PAT_IDENT, PAT_FULL,  PAT_FULL,  EXP_MODEL,  1'b0};
        stim_tab[1] = '{PAT_MAX,   PAT_MAX,   PAT_MAX,   EXP_SAT_HI, 1'b0};
        stim_tab[2] = '{PAT_MAX,   PAT_MAX,   PAT_MIN,   EXP_SAT_LO, 1'b0};
        stim_tab[3] = '{PAT_SMALL, PAT_SMALL, PAT_SMALL, EXP_MODEL,  1'b0};
        stim_tab[4] = '{PAT_FULL,  PAT_FULL,  PAT_FULL,  EXP_MODEL,  1'b1};
        stim_tab[5] = '{PAT_MIN,   PAT_MIN,   PAT_MIN,   EXP_SAT_LO, 1'b0};
    endtask

    initial begin
        first_rnd  = $urandom(SEED);
        errors     = 0;
        timeouts   = 0;
        ended      = 1'b0;
        arst_n     = 1'b0;
        attn_start = 1'b0;
        load_en    = 1'b0;
        load_slot  = SLOT_Q;
        load_mat   = '0;
        rd_en      = 1'b0;
        rd_slot    = SLOT_Q;
        fill_table();
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_reset_state();
        for (int r = 0; r < TAB_LEN; r++) begin
            run_row(r);
        end
        $display("summary: %0d check failures, %0d timeouts", errors, timeouts);
        ended = 1'b1;
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // run stopped early, e.g. by a bound assertion
    final begin
        if (!ended) begin
            $display("tests failed");
        end
    end

endmodule

// ==== compile.f ====
verilog/attn_pkg.sv
verilog/mem_pkg.sv
verilog/attn_ctrl.sv
verilog/mat_buffer.sv
verilog/systolic_array.sv
verilog/attn_top.sv
tests/attn_checker.sv
tests/attn_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the attention engine testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module attn_tb -f compile.f -o attn_sim &&
./obj_dir/attn_sim | tee /dev/stderr | grep -q "all tests passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
